// File: flist.f
+incdir+.
quplsIsaPkg.sv
quplsDecodePkg.sv
quplsDecodeIf.sv
quplsDecodeMem.sv
quplsDecodeAlu.sv
quplsDecodeOperands.sv
quplsDecodeStage.sv
tbDecodeStage.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.
# The run passes only if the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module tbDecodeStage -o simDecode \
	&& ./obj_dir/simDecode | tee sim.log \
	|| { echo "Build or run failed"; exit 1; }

grep -q "^No errors$" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: tbDecodeStage.sv
// ==========================================================
// Decode stage testbench
// Directed and random instructions against a rule-based model
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "qupls_defines.svh"

module tbDecodeStage;
	import quplsIsaPkg::*;
	import quplsDecodePkg::*;

	// Covers reset, about fifty directed cycles and the random run with margin
	localparam int cycleLimit = 600;
	localparam int randomCount = 400;

	logic clk;
	logic rstN;
	logic instrValid;
	instruction_t instr;
	logic stall;
	logic decValid;
	logic store;
	logic cstore;
	logic load;
	memSize_e memSize;
	aluOp_e aluOp;
	logic illegal;
	logic [`QUPLS_REG_W-1:0] rd;
	logic [`QUPLS_REG_W-1:0] rs1;
	logic [`QUPLS_REG_W-1:0] rs2;
	logic writesRd;
	logic hasImm;
	logic [`QUPLS_WORD_W-1:0] imm;

	// Expected register contents and the DUT outputs as one bundle
	decoded_t expQ;
	logic expValid;
	decoded_t actual;

	opcode_e legalOps [0:18];
	logic [`QUPLS_INSTR_W-1:0] word;
	instruction_t nextInstr;
	logic nextValid;
	logic held;
	integer seed;
	int errCount;
	int cycles;
	int idx;
	int k;
	int n;

	quplsDecodeStage dut0 (.*);

	always #4 clk = ~clk;

	// ==========================================================
	// Reference model
	// ==========================================================
	function automatic decoded_t resetBundle();
		decoded_t b;
		b = '0;
		b.memSize = SZ_NONE;
		b.aluOp = ALU_NONE;
		return b;
	endfunction

	// Only ALU forms are mapped here and the caller handles memory forms
	function automatic aluOp_e aluOpFor(input opcode_e opc);
		case (opc)
		OP_ADD, OP_ADDI:
			return ALU_ADD;
		OP_SUB:
			return ALU_SUB;
		OP_AND, OP_ANDI:
			return ALU_AND;
		OP_OR, OP_ORI:
			return ALU_OR;
		OP_XOR:
			return ALU_XOR;
		default:
			return ALU_NONE;
		endcase
	endfunction

	// Sizes run from byte to hexi and cstore moves an octa
	function automatic memSize_e sizeFor(input opcode_e opc);
		case (opc)
		OP_LDB, OP_STB:
			return SZ_BYTE;
		OP_LDW, OP_STW:
			return SZ_WYDE;
		OP_LDT, OP_STT:
			return SZ_TETRA;
		OP_LDO, OP_STO, OP_CSTORE:
			return SZ_OCTA;
		OP_STH:
			return SZ_HEXI;
		default:
			return SZ_NONE;
		endcase
	endfunction

	function automatic decoded_t expectedDecode(input instruction_t i);
		decoded_t e;
		e = resetBundle();
		// Register fields pass through for every code including illegal ones
		e.rd = i.rd;
		e.rs1 = i.rs1;
		e.aluOp = aluOpFor(i.opcode);
		e.memSize = sizeFor(i.opcode);
		case (i.opcode)
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
		begin
			e.writesRd = 1'b1;
			e.rs2 = i.imm[`QUPLS_REG_W-1:0];
		end
		OP_ADDI, OP_ANDI, OP_ORI:
		begin
			e.writesRd = 1'b1;
			e.hasImm = 1'b1;
		end
		OP_LDB, OP_LDW, OP_LDT, OP_LDO:
		begin
			e.load = 1'b1;
			e.writesRd = 1'b1;
			e.hasImm = 1'b1;
			e.aluOp = ALU_ADD;
		end
		// A store reads rd as its data, so nothing is written
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STH:
		begin
			e.store = 1'b1;
			e.hasImm = 1'b1;
			e.aluOp = ALU_ADD;
		end
		OP_CSTORE:
		begin
			e.cstore = 1'b1;
			e.rs2 = i.imm[`QUPLS_REG_W-1:0];
			e.aluOp = ALU_ADD;
		end
		OP_NOP:
			e.illegal = 1'b0;
		default:
			e.illegal = 1'b1;
		endcase
		if (e.hasImm)
			e.imm = 64'($signed(i.imm));
		return e;
	endfunction

	// Captures like the stage register and freezes on stall
	always @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			expQ <= resetBundle();
			expValid <= 1'b0;
		end
		else if (!stall)
		begin
			expQ <= expectedDecode(instr);
			expValid <= instrValid;
		end
	end

	assign actual = '{store, cstore, load, memSize, aluOp, illegal, rd, rs1, rs2,
		writesRd, hasImm, imm};

	// ==========================================================
	// Checks
	// ==========================================================
	task automatic flagMismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		errCount++;
		$display("FAILED %s: got %h expected %h", name, got, want);
	endtask

	task automatic noteFailure(input string what);
		errCount++;
		$display("ERROR: %s", what);
	endtask

	// Outputs settle after the rising edge, so compare them on the falling one
	assert property (@(negedge clk) decValid == expValid)
		else flagMismatch("decValid", 64'(decValid), 64'(expValid));
	assert property (@(negedge clk) store == expQ.store)
		else flagMismatch("store", 64'(store), 64'(expQ.store));
	assert property (@(negedge clk) cstore == expQ.cstore)
		else flagMismatch("cstore", 64'(cstore), 64'(expQ.cstore));
	assert property (@(negedge clk) load == expQ.load)
		else flagMismatch("load", 64'(load), 64'(expQ.load));
	assert property (@(negedge clk) memSize == expQ.memSize)
		else flagMismatch("memSize", 64'(memSize), 64'(expQ.memSize));
	assert property (@(negedge clk) aluOp == expQ.aluOp)
		else flagMismatch("aluOp", 64'(aluOp), 64'(expQ.aluOp));
	assert property (@(negedge clk) illegal == expQ.illegal)
		else flagMismatch("illegal", 64'(illegal), 64'(expQ.illegal));
	assert property (@(negedge clk) rd == expQ.rd)
		else flagMismatch("rd", 64'(rd), 64'(expQ.rd));
	assert property (@(negedge clk) rs1 == expQ.rs1)
		else flagMismatch("rs1", 64'(rs1), 64'(expQ.rs1));
	assert property (@(negedge clk) rs2 == expQ.rs2)
		else flagMismatch("rs2", 64'(rs2), 64'(expQ.rs2));
	assert property (@(negedge clk) writesRd == expQ.writesRd)
		else flagMismatch("writesRd", 64'(writesRd), 64'(expQ.writesRd));
	assert property (@(negedge clk) hasImm == expQ.hasImm)
		else flagMismatch("hasImm", 64'(hasImm), 64'(expQ.hasImm));
	assert property (@(negedge clk) imm == expQ.imm)
		else flagMismatch("imm", imm, expQ.imm);

	// The cycle after reset shows the idle bundle
	assert property (@(posedge clk) !rstN |=> (!decValid && !store && !cstore && !load
		&& !writesRd && !hasImm && !illegal && aluOp == ALU_NONE && memSize == SZ_NONE))
		else noteFailure("outputs were not idle after reset");
	assert property (@(posedge clk) disable iff (!rstN)
		stall |=> ($stable(actual) && $stable(decValid)))
		else noteFailure("an output changed during a stall cycle");
	assert property (@(posedge clk) disable iff (!rstN)
		(instrValid && !stall) |=> decValid)
		else noteFailure("an accepted instruction did not raise decValid");
	assert property (@(posedge clk) disable iff (!rstN)
		(!instrValid && !stall) |=> !decValid)
		else noteFailure("decValid stayed high after an empty cycle");

	// ==========================================================
	// Stimulus
	// ==========================================================
	function automatic instruction_t packInstr(input logic [6:0] opc,
		input logic [5:0] rdv, input logic [5:0] rs1v, input logic [12:0] immv);
		return instruction_t'({immv, rs1v, rdv, opc});
	endfunction

	task automatic applyInstr(input instruction_t i, input logic v, input logic s);
		@(posedge clk);
		instr <= i;
		instrValid <= v;
		stall <= s;
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("Timeout: the run reached %0d cycles without finishing", cycles);
			$display("Errors found");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		stall = 1'b0;
		instr = '0;
		seed = 32'h0629_c3dc;
		errCount = 0;
		cycles = 0;
		held = 1'b0;
		nextValid = 1'b0;
		word = '0;
		legalOps = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_ANDI, OP_ORI,
			OP_LDB, OP_LDW, OP_LDT, OP_LDO, OP_STB, OP_STW, OP_STT, OP_STO, OP_STH,
			OP_CSTORE, OP_NOP};

		// Two rising edges with reset held low
		repeat (2) @(posedge clk);
		rstN <= 1'b1;

		// Every listed opcode with a positive field and rd 0 first
		for (k = 0; k < 19; k++)
			applyInstr(packInstr(legalOps[k], 6'(k), 6'(k + 7), 13'h0120 | 13'(k)), 1'b1,
				1'b0);

		// Negative fields where every fifth instruction first waits out a stall cycle
		for (k = 0; k < 19; k++)
		begin
			nextInstr = packInstr(legalOps[k], 6'(63 - k), 6'(k), 13'h1F00 | 13'(k));
			if (k % 5 == 4)
				applyInstr(nextInstr, 1'b1, 1'b1);
			applyInstr(nextInstr, 1'b1, 1'b0);
		end
		applyInstr(nextInstr, 1'b0, 1'b0);

		// Codes outside the instruction set
		applyInstr(packInstr(7'h00, 6'd1, 6'd2, 13'h1FFF), 1'b1, 1'b0);
		applyInstr(packInstr(7'h03, 6'd9, 6'd3, 13'h0015), 1'b1, 1'b0);
		applyInstr(packInstr(7'h2A, 6'd0, 6'd63, 13'h1000), 1'b1, 1'b0);
		applyInstr(packInstr(7'h7E, 6'd33, 6'd17, 13'h0FFF), 1'b1, 1'b0);

		// Random mix where half of the words get a listed opcode
		for (n = 0; n < randomCount; n++)
		begin
			// A stalled instruction stays on the inputs until it is taken
			if (!held)
			begin
				word = $random(seed);
				if ($random(seed) & 1)
				begin
					idx = $unsigned($random(seed)) % 19;
					word[6:0] = legalOps[idx];
				end
				nextValid = ($random(seed) & 7) != 0;
			end
			held = ($random(seed) & 3) == 0;
			applyInstr(instruction_t'(word), nextValid, held);
		end

		// Let the last instruction reach the outputs and be checked
		applyInstr(instruction_t'(word), 1'b0, 1'b0);
		@(posedge clk);
		@(negedge clk);

		$display("Run finished after %0d cycles with %0d errors", cycles, errCount);
		if (errCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: quplsDecodeStage.sv
// ==========================================================
// Instruction decode stage
// Three sub-decoders feeding one stall-held pipeline register
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "qupls_defines.svh"

module quplsDecodeStage (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input quplsIsaPkg::instruction_t instr,
	input logic stall,
	output logic decValid,
	output logic store,
	output logic cstore,
	output logic load,
	output quplsDecodePkg::memSize_e memSize,
	output quplsDecodePkg::aluOp_e aluOp,
	output logic illegal,
	output logic [`QUPLS_REG_W-1:0] rd,
	output logic [`QUPLS_REG_W-1:0] rs1,
	output logic [`QUPLS_REG_W-1:0] rs2,
	output logic writesRd,
	output logic hasImm,
	output logic [`QUPLS_WORD_W-1:0] imm
);
	import quplsDecodePkg::*;

	// Inactive bundle with every flag low for the reset
	localparam decoded_t idleBundle = '{
		memSize: SZ_NONE,
		aluOp: ALU_NONE,
		default: '0
	};

	decoded_t decD;
	decoded_t decQ;

	// ==========================================================
	// Sub-decoders
	// ==========================================================
	quplsDecodeIf decIf (.clk(clk), .rstN(rstN));

	quplsDecodeMem memDec (.instr(instr), .mem(decIf.memSrc));
	quplsDecodeAlu aluDec (.instr(instr), .alu(decIf.aluSrc));
	quplsDecodeOperands opDec (.instr(instr), .ops(decIf.opSrc));

	// Gather the interface into one bundle
	always_comb
	begin
		decD.store = decIf.store;
		decD.cstore = decIf.cstore;
		decD.load = decIf.load;
		decD.memSize = decIf.memSize;
		decD.aluOp = decIf.aluOp;
		decD.illegal = decIf.illegal;
		decD.rd = decIf.rd;
		decD.rs1 = decIf.rs1;
		decD.rs2 = decIf.rs2;
		decD.writesRd = decIf.writesRd;
		decD.hasImm = decIf.hasImm;
		decD.imm = decIf.imm;
	end

	// ==========================================================
	// Pipeline register
	// ==========================================================
	// Stall freezes both the bundle and the valid strobe
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			decQ <= idleBundle;
			decValid <= 1'b0;
		end
		else if (!stall)
		begin
			decQ <= decD;
			decValid <= instrValid;
		end
	end

	assign store = decQ.store;
	assign cstore = decQ.cstore;
	assign load = decQ.load;
	assign memSize = decQ.memSize;
	assign aluOp = decQ.aluOp;
	assign illegal = decQ.illegal;
	assign rd = decQ.rd;
	assign rs1 = decQ.rs1;
	assign rs2 = decQ.rs2;
	assign writesRd = decQ.writesRd;
	assign hasImm = decQ.hasImm;
	assign imm = decQ.imm;

	// A stall cycle leaves every output exactly as it was
	assert property (@(posedge clk) disable iff (!rstN)
		stall |=> ($stable(decQ) && $stable(decValid)));

endmodule

`default_nettype wire

// File: quplsDecodeOperands.sv
// ==========================================================
// Operand decoder
// Register numbers, destination write and sign-extended immediate
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "qupls_defines.svh"

module quplsDecodeOperands (
	input quplsIsaPkg::instruction_t instr,
	quplsDecodeIf.opSrc ops
);
	import quplsIsaPkg::*;

	// Local opcode classes, decoded here and nowhere else
	logic isRegAlu;
	logic isImmAlu;
	logic isLoad;
	logic isStore;
	logic isCStore;

	always_comb
	begin
		isRegAlu = 1'b0;
		isImmAlu = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isCStore = 1'b0;
		case (instr.opcode)
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
			isRegAlu = 1'b1;
		OP_ADDI, OP_ANDI, OP_ORI:
			isImmAlu = 1'b1;
		OP_LDB, OP_LDW, OP_LDT, OP_LDO:
			isLoad = 1'b1;
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STH:
			isStore = 1'b1;
		OP_CSTORE:
			isCStore = 1'b1;
		default:
			isRegAlu = 1'b0;
		endcase
	end

	// rd and rs1 pass through even for illegal codes
	assign ops.rd = instr.rd;
	assign ops.rs1 = instr.rs1;

	// Second source lives in the low imm bits, zero when unused
	assign ops.rs2 = (isRegAlu || isCStore) ? instr.imm[`QUPLS_REG_W-1:0] : '0;

	// Stores use rd as data source, so only ALU forms and loads write it
	assign ops.writesRd = isRegAlu || isImmAlu || isLoad;
	assign ops.hasImm = isImmAlu || isLoad || isStore;

	// Replicate the top bit of the field up to the word width
	assign ops.imm = ops.hasImm ?
		{{(`QUPLS_WORD_W-`QUPLS_IMM_W){instr.imm[`QUPLS_IMM_W-1]}}, instr.imm} : '0;

endmodule

`default_nettype wire

// File: quplsDecodeAlu.sv
// ==========================================================
// ALU decoder
// Gives the ALU operation and flags unknown opcodes
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module quplsDecodeAlu (
	input quplsIsaPkg::instruction_t instr,
	quplsDecodeIf.aluSrc alu
);
	import quplsIsaPkg::*;
	import quplsDecodePkg::*;

	always_comb
	begin
		alu.illegal = 1'b0;
		case (instr.opcode)
		// Register and immediate forms share an operation
		OP_ADD, OP_ADDI:
			alu.aluOp = ALU_ADD;
		OP_SUB:
			alu.aluOp = ALU_SUB;
		OP_AND, OP_ANDI:
			alu.aluOp = ALU_AND;
		OP_OR, OP_ORI:
			alu.aluOp = ALU_OR;
		OP_XOR:
			alu.aluOp = ALU_XOR;
		// Every memory access adds its displacement to rs1
		OP_LDB, OP_LDW, OP_LDT, OP_LDO,
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STH, OP_CSTORE:
			alu.aluOp = ALU_ADD;
		OP_NOP:
			alu.aluOp = ALU_NONE;
		// Anything else is not part of the instruction set
		default:
		begin
			alu.aluOp = ALU_NONE;
			alu.illegal = 1'b1;
		end
		endcase
	end

	// An illegal instruction must never reach execute with an operation
	assert property (@(posedge alu.clk) disable iff (!alu.rstN)
		alu.illegal |-> (alu.aluOp == ALU_NONE));

endmodule

`default_nettype wire

// File: quplsDecodeMem.sv
// ==========================================================
// Memory class decoder
// Flags stores, conditional stores and loads with their size
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module quplsDecodeMem (
	input quplsIsaPkg::instruction_t instr,
	quplsDecodeIf.memSrc mem
);
	import quplsIsaPkg::*;
	import quplsDecodePkg::*;

	// Plain stores, all five sizes
	function automatic logic fnIsStore(input instruction_t op);
		case (op.opcode)
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STH:
			fnIsStore = 1'b1;
		default:
			fnIsStore = 1'b0;
		endcase
	endfunction

	// Conditional store is kept apart from the plain stores
	function automatic logic fnIsCStore(input instruction_t op);
		case (op.opcode)
		OP_CSTORE:
			fnIsCStore = 1'b1;
		default:
			fnIsCStore = 1'b0;
		endcase
	endfunction

	function automatic logic fnIsLoad(input instruction_t op);
		case (op.opcode)
		OP_LDB, OP_LDW, OP_LDT, OP_LDO:
			fnIsLoad = 1'b1;
		default:
			fnIsLoad = 1'b0;
		endcase
	endfunction

	// Size follows the last letter of the mnemonic, cstore moves an octa
	function automatic memSize_e fnMemSize(input instruction_t op);
		case (op.opcode)
		OP_LDB, OP_STB:
			fnMemSize = SZ_BYTE;
		OP_LDW, OP_STW:
			fnMemSize = SZ_WYDE;
		OP_LDT, OP_STT:
			fnMemSize = SZ_TETRA;
		OP_LDO, OP_STO, OP_CSTORE:
			fnMemSize = SZ_OCTA;
		OP_STH:
			fnMemSize = SZ_HEXI;
		default:
			fnMemSize = SZ_NONE;
		endcase
	endfunction

	assign mem.store = fnIsStore(instr);
	assign mem.cstore = fnIsCStore(instr);
	assign mem.load = fnIsLoad(instr);
	assign mem.memSize = fnMemSize(instr);

	// The class functions and the size table must agree on every opcode
	assert property (@(posedge mem.clk) disable iff (!mem.rstN)
		$onehot0({mem.store, mem.cstore, mem.load}));
	assert property (@(posedge mem.clk) disable iff (!mem.rstN)
		(mem.memSize == SZ_NONE) == !(mem.store || mem.cstore || mem.load));

endmodule

`default_nettype wire

// File: quplsDecodeIf.sv
// ==========================================================
// Decode result interface
// Collects the three sub-decoder outputs for the stage register
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

`include "qupls_defines.svh"

interface quplsDecodeIf (
	input logic clk,
	input logic rstN
);
	import quplsDecodePkg::*;

	// Memory class results
	logic store;
	logic cstore;
	logic load;
	memSize_e memSize;

	// ALU class results
	aluOp_e aluOp;
	logic illegal;

	// Operand results
	logic [`QUPLS_REG_W-1:0] rd;
	logic [`QUPLS_REG_W-1:0] rs1;
	logic [`QUPLS_REG_W-1:0] rs2;
	logic writesRd;
	logic hasImm;
	logic [`QUPLS_WORD_W-1:0] imm;

	// Clock and reset reach the checking producers for their assertions
	modport memSrc (input clk, input rstN, output store, output cstore, output load,
		output memSize);
	modport aluSrc (input clk, input rstN, output aluOp, output illegal);
	modport opSrc (output rd, output rs1, output rs2, output writesRd, output hasImm,
		output imm);

	// The stage register reads everything
	modport sink (input store, input cstore, input load, input memSize, input aluOp,
		input illegal, input rd, input rs1, input rs2, input writesRd, input hasImm,
		input imm);

endinterface

`default_nettype wire

// File: quplsDecodePkg.sv
// ==========================================================
// Decode-result package
// ALU operations, access sizes and the registered bundle
// ==========================================================

`default_nettype none

`include "qupls_defines.svh"

package quplsDecodePkg;

	// Operation handed to the execute stage
	// Memory operations use ALU_ADD to form the address
	typedef enum logic [2:0]
	{
		ALU_NONE = 3'd0,
		ALU_ADD  = 3'd1,
		ALU_SUB  = 3'd2,
		ALU_AND  = 3'd3,
		ALU_OR   = 3'd4,
		ALU_XOR  = 3'd5
	} aluOp_e;

	// Access size of 1, 2, 4, 8 or 16 bytes
	typedef enum logic [2:0]
	{
		SZ_NONE  = 3'd0,
		SZ_BYTE  = 3'd1,
		SZ_WYDE  = 3'd2,
		SZ_TETRA = 3'd3,
		SZ_OCTA  = 3'd4,
		SZ_HEXI  = 3'd5
	} memSize_e;

	// Full decode result as held in the stage register
	typedef struct packed
	{
		logic                     store;
		logic                     cstore;
		logic                     load;
		memSize_e                 memSize;
		aluOp_e                   aluOp;
		logic                     illegal;
		logic [`QUPLS_REG_W-1:0]  rd;
		logic [`QUPLS_REG_W-1:0]  rs1;
		logic [`QUPLS_REG_W-1:0]  rs2;
		logic                     writesRd;
		logic                     hasImm;
		logic [`QUPLS_WORD_W-1:0] imm;
	} decoded_t;

endpackage

`default_nettype wire

// File: quplsIsaPkg.sv
// ==========================================================
// Instruction-set package
// Opcode encodings and the instruction field layout
// ==========================================================

`default_nettype none

`include "qupls_defines.svh"

package quplsIsaPkg;

	// ==========================================================
	// Opcodes
	// ==========================================================
	// Codes not listed here are illegal and are flagged by the ALU decoder
	typedef enum logic [`QUPLS_OPC_W-1:0]
	{
		// Register ALU forms, second source in the low imm bits
		OP_ADD    = 7'h04,
		OP_SUB    = 7'h05,
		OP_AND    = 7'h08,
		OP_OR     = 7'h09,
		OP_XOR    = 7'h0A,
		// Immediate ALU forms
		OP_ADDI   = 7'h14,
		OP_ANDI   = 7'h18,
		OP_ORI    = 7'h19,
		// Loads, byte through octa
		OP_LDB    = 7'h40,
		OP_LDW    = 7'h41,
		OP_LDT    = 7'h42,
		OP_LDO    = 7'h43,
		// Stores, byte through hexi
		OP_STB    = 7'h50,
		OP_STW    = 7'h51,
		OP_STT    = 7'h52,
		OP_STO    = 7'h53,
		OP_STH    = 7'h54,
		// Conditional store and no-operation
		OP_CSTORE = 7'h5C,
		OP_NOP    = 7'h7F
	} opcode_e;

	// ==========================================================
	// Instruction layout
	// ==========================================================
	// Fields run from the top bit down, opcode sits in the low bits
	typedef struct packed
	{
		// Also carries rs2 in its low bits for register forms
		logic [`QUPLS_IMM_W-1:0] imm;
		logic [`QUPLS_REG_W-1:0] rs1;
		// Destination, or the data source for a store
		logic [`QUPLS_REG_W-1:0] rd;
		opcode_e                 opcode;
	} instruction_t;

endpackage

`default_nettype wire

// File: qupls_defines.svh
// ==========================================================
// Decode stage widths
// Instruction, data word, register number and immediate field
// ==========================================================

`ifndef QUPLS_DEFINES_SVH
`define QUPLS_DEFINES_SVH

// Every instruction is one fixed-size word
`define QUPLS_INSTR_W 32

// Width of a general register and of the extended immediate
`define QUPLS_WORD_W 64

// Six bits select one of 64 architectural registers
`define QUPLS_REG_W 6

// Width of the raw immediate field in the instruction word
`define QUPLS_IMM_W 13

// Width of the opcode field at the bottom of the word
`define QUPLS_OPC_W 7

`endif
